/* rtl/memtest_cfg.svh */
`ifndef MEMTEST_CFG_SVH
`define MEMTEST_CFG_SVH

// test memory geometry
// depth is kept small so a full pass runs in a few dozen clocks
`define MT_DEPTH 16

// one stored word, matches the 16-bit LFSR state
`define MT_WIDTH 16

// LFSR start value, reloaded at the start of the write phase
// and again at the start of the verify phase
// must not be zero or the sequence sticks
`define MT_SEED 16'hACE1

// pixel clocks per elapsed second
// a 25 MHz pixel clock would need 25_000_000 here,
// simulation uses a short second so the clock visibly moves
`define MT_SEC_TICKS 50

// elapsed clock limits
`define MT_SECS_PER_MIN 60

`endif

/* rtl/memtest_pkg.sv */
package memtest_pkg;

    // one-cycle pulses from the button decoder to the pattern engine
    typedef struct packed {
        logic start;
        logic inject;
    } mt_cmd_t;

    // elapsed display word, read as mm:ss or as a signed phase value
    typedef union packed {
        struct packed {
            logic [7:0] mins;
            logic [7:0] secs;
        } tm;
        logic signed [15:0] phase;
    } mt_status_u;

    // clock frequency settings selectable with up/down
    localparam int MT_FREQ_N = 11;

    // index 0 is the fastest setting
    localparam logic [10:0] MT_FREQ_TABLE [MT_FREQ_N] = '{
        11'h167,
        11'h160,
        11'h150,
        11'h140,
        11'h130,
        11'h120,
        11'h110,
        11'h100,
        11'h090,
        11'h080,
        11'h070
    };

    // highest legal value of the frequency index
    localparam logic [3:0] MT_POS_MAX = 4'(MT_FREQ_N - 1);

endpackage

/* rtl/memtest_if.sv */
`timescale 1ns/1ns

// pass results from the pattern engine to the result stage
interface memtest_if;

    // one clock wide, marks the end of a write+verify pass
    logic       pass_done;

    // pass result, valid together with pass_done
    logic       pass_ok;

    // high from the clock after start until pass_done
    logic       busy;

    // mismatches seen in the last pass, saturates at 255
    logic [7:0] err_count;

    modport engine (
        output pass_done,
        output pass_ok,
        output busy,
        output err_count
    );

    modport tally (
        input pass_done,
        input pass_ok,
        input busy,
        input err_count
    );

endinterface

/* rtl/cmd_decode.sv */
`timescale 1ns/1ns

module cmd_decode
    import memtest_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        rst_n,
    input  logic [5:0]  btn,
    input  logic        pass_done,
    output mt_cmd_t     cmd,
    output logic        auto_mode,
    output logic        ph_mode,
    output logic [3:0]  pos,
    output logic [15:0] phase
);

    // button bit positions
    localparam int BTN_START  = 0;
    localparam int BTN_AUTO   = 1;
    localparam int BTN_UP     = 2;
    localparam int BTN_DOWN   = 3;
    localparam int BTN_PHASE  = 4;
    localparam int BTN_INJECT = 5;

    logic [5:0] sync_a;
    logic [5:0] sync_b;
    logic [5:0] btn_prev;
    logic [5:0] rise;
    logic       start_fire;
    logic       inj_armed;

    // two flops against metastability, then one more for edge detect
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            sync_a   <= '0;
            sync_b   <= '0;
            btn_prev <= '0;
        end
        else
        begin
            sync_a   <= btn;
            sync_b   <= sync_a;
            btn_prev <= sync_b;
        end
    end

    assign rise = sync_b & ~btn_prev;

    // a start comes from the button, from switching auto on,
    // or from the end of a pass while auto is running
    assign start_fire = rise[BTN_START]
                      | (rise[BTN_AUTO] & ~auto_mode)
                      | (auto_mode & pass_done);

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            cmd       <= '0;
            inj_armed <= 1'b0;
            auto_mode <= 1'b0;
            ph_mode   <= 1'b0;
            pos       <= '0;
            phase     <= '0;
        end
        else
        begin
            cmd.start  <= start_fire;
            cmd.inject <= start_fire & inj_armed;

            // armed flag is handed over with the next start
            if (start_fire)
                inj_armed <= 1'b0;
            else if (rise[BTN_INJECT])
                inj_armed <= 1'b1;

            if (rise[BTN_AUTO])
                auto_mode <= ~auto_mode;
            if (rise[BTN_PHASE])
                ph_mode <= ~ph_mode;

            // up/down steer the phase value or the frequency index
            if (ph_mode)
            begin
                if (rise[BTN_UP])
                    phase <= phase + 16'd1;
                else if (rise[BTN_DOWN])
                    phase <= phase - 16'd1;
            end
            else
            begin
                if (rise[BTN_UP] && pos != MT_POS_MAX)
                    pos <= pos + 4'd1;
                else if (rise[BTN_DOWN] && pos != 4'd0)
                    pos <= pos - 4'd1;
            end
        end
    end

    // pos indexes the frequency table in the result stage
    a_pos_in_table: assert property (
        @(posedge clk_pixel) disable iff (!rst_n) pos <= MT_POS_MAX
    ) else $error("frequency index out of table range");

endmodule

/* rtl/pattern_engine.sv */
`timescale 1ns/1ns
`include "memtest_cfg.svh"

module pattern_engine
    import memtest_pkg::*;
(
    input  logic      clk_pixel,
    input  logic      rst_n,
    input  mt_cmd_t   cmd,
    memtest_if.engine res
);

    localparam int AW = $clog2(`MT_DEPTH);
    localparam logic [AW-1:0] LAST_ADDR = AW'(`MT_DEPTH - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_DRAIN
    } state_t;

    state_t               state;
    logic [AW-1:0]        addr;
    logic [15:0]          lfsr;
    logic [15:0]          lfsr_next;
    logic                 inj_q;
    logic [`MT_WIDTH-1:0] pattern;
    logic [`MT_WIDTH-1:0] wr_data;
    logic                 wr_en;
    logic                 rd_en;
    logic [`MT_WIDTH-1:0] rd_data;
    logic [`MT_WIDTH-1:0] expect_q;
    logic                 rd_valid;
    logic                 rd_last;
    logic                 mismatch;
    logic [7:0]           err_cnt;
    logic [7:0]           err_next;

    logic [`MT_WIDTH-1:0] mem [`MT_DEPTH];

    // x^16 + x^14 + x^13 + x^11 + 1, one step per word
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    assign pattern   = `MT_WIDTH'(lfsr);

    // fault injection flips bit 0 of word 0 on the way in
    assign wr_data = pattern ^ `MT_WIDTH'(inj_q && addr == '0);
    assign wr_en   = (state == ST_WRITE);
    assign rd_en   = (state == ST_READ);

    always_ff @(posedge clk_pixel)
    begin
        if (wr_en)
            mem[addr] <= wr_data;
        rd_data  <= mem[addr];
        // expected word travels alongside the registered read
        expect_q <= pattern;
    end

    assign mismatch = (rd_data != expect_q);
    assign err_next = (mismatch && err_cnt != 8'hFF) ? err_cnt + 8'd1 : err_cnt;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            state         <= ST_IDLE;
            addr          <= '0;
            lfsr          <= `MT_SEED;
            inj_q         <= 1'b0;
            rd_valid      <= 1'b0;
            rd_last       <= 1'b0;
            err_cnt       <= '0;
            res.busy      <= 1'b0;
            res.pass_done <= 1'b0;
            res.pass_ok   <= 1'b0;
            res.err_count <= '0;
        end
        else
        begin
            res.pass_done <= 1'b0;
            rd_valid      <= rd_en;
            rd_last       <= rd_en && addr == LAST_ADDR;

            case (state)
                ST_IDLE:
                begin
                    // starts while busy never reach this branch
                    if (cmd.start)
                    begin
                        state    <= ST_WRITE;
                        res.busy <= 1'b1;
                        addr     <= '0;
                        lfsr     <= `MT_SEED;
                        inj_q    <= cmd.inject;
                        err_cnt  <= '0;
                    end
                end
                ST_WRITE:
                begin
                    addr <= addr + 1'b1;
                    lfsr <= lfsr_next;
                    if (addr == LAST_ADDR)
                    begin
                        state <= ST_READ;
                        addr  <= '0;
                        lfsr  <= `MT_SEED;
                    end
                end
                ST_READ:
                begin
                    addr <= addr + 1'b1;
                    lfsr <= lfsr_next;
                    if (addr == LAST_ADDR)
                        state <= ST_DRAIN;
                end
                default:
                begin
                    // wait for the last compare
                end
            endcase

            if (rd_valid)
                err_cnt <= err_next;

            if (rd_valid && rd_last)
            begin
                state         <= ST_IDLE;
                res.busy      <= 1'b0;
                res.pass_done <= 1'b1;
                res.pass_ok   <= (err_next == 8'd0);
                res.err_count <= err_next;
            end
        end
    end

    // busy drops on the same edge that raises pass_done
    a_done_in_pass: assert property (
        @(posedge clk_pixel) disable iff (!rst_n) res.pass_done |-> $past(res.busy)
    ) else $error("pass_done outside a running pass");

endmodule

/* rtl/result_tally.sv */
`timescale 1ns/1ns
`include "memtest_cfg.svh"

module result_tally
    import memtest_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        rst_n,
    memtest_if.tally    res,
    input  logic        auto_mode,
    input  logic        ph_mode,
    input  logic [3:0]  pos,
    input  logic [15:0] phase,
    output logic [31:0] pass_count,
    output logic [31:0] fail_count,
    output logic [15:0] freq,
    output logic [15:0] elapsed,
    output logic [7:0]  mark
);

    localparam int TICK_W = $clog2(`MT_SEC_TICKS);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`MT_SEC_TICKS - 1);
    localparam logic [7:0] SEC_LAST = 8'(`MT_SECS_PER_MIN - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [7:0]        secs;
    logic [7:0]        mins;
    mt_status_u        status;

    // pass and fail counters update one clock behind pass_done
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            pass_count <= '0;
            fail_count <= '0;
        end
        else if (res.pass_done)
        begin
            if (res.pass_ok)
                pass_count <= pass_count + 32'd1;
            else
                fail_count <= fail_count + 32'd1;
        end
    end

    // free running mm:ss since reset
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            tick_cnt <= '0;
            secs     <= '0;
            mins     <= '0;
        end
        else if (tick_cnt == TICK_LAST)
        begin
            tick_cnt <= '0;
            if (secs == SEC_LAST)
            begin
                secs <= '0;
                mins <= mins + 8'd1;
            end
            else
            begin
                secs <= secs + 8'd1;
            end
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_comb
    begin
        status = '0;
        if (ph_mode)
        begin
            status.phase = signed'(phase);
        end
        else
        begin
            status.tm.mins = mins;
            status.tm.secs = secs;
        end
    end

    assign elapsed = status;
    assign freq    = 16'hF000 | {5'd0, MT_FREQ_TABLE[pos]};

    // running light on the mark byte while auto-repeat is on
    assign mark = ph_mode   ? 8'hF0 :
                  auto_mode ? 8'h80 >> secs[3:0] :
                              8'h00;

    // a pass compares MT_DEPTH words and cannot report more mismatches than that
    a_err_within_depth: assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        res.pass_done |-> (int'(res.err_count) <= `MT_DEPTH)
    ) else $error("err_count exceeds the words checked in one pass");

endmodule

/* rtl/memtest_top.sv */
`timescale 1ns/1ns

module memtest_top
    import memtest_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        rst_n,
    input  logic [5:0]  btn,
    output logic [31:0] pass_count,
    output logic [31:0] fail_count,
    output logic [15:0] freq,
    output logic [15:0] elapsed,
    output logic [7:0]  mark,
    output logic        busy
);

    mt_cmd_t     cmd;
    logic        auto_mode;
    logic        ph_mode;
    logic [3:0]  pos;
    logic [15:0] phase;

    // results of each pass, engine to tally
    memtest_if res_if ();

    // buttons to commands and display modes
    cmd_decode u_decode (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .btn       (btn),
        .pass_done (res_if.pass_done),
        .cmd       (cmd),
        .auto_mode (auto_mode),
        .ph_mode   (ph_mode),
        .pos       (pos),
        .phase     (phase)
    );

    pattern_engine u_engine (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .res       (res_if.engine)
    );

    result_tally u_tally (
        .clk_pixel  (clk_pixel),
        .rst_n      (rst_n),
        .res        (res_if.tally),
        .auto_mode  (auto_mode),
        .ph_mode    (ph_mode),
        .pos        (pos),
        .phase      (phase),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .freq       (freq),
        .elapsed    (elapsed),
        .mark       (mark)
    );

    assign busy = res_if.busy;

endmodule

/* bench/memtest_tb.sv */
`timescale 1ns/1ns
`include "memtest_cfg.svh"

module memtest_tb
    import memtest_pkg::*;
();

    // button masks, one bit per push-button
    localparam logic [5:0] B_NONE  = 6'h00;
    localparam logic [5:0] B_START = 6'h01;
    localparam logic [5:0] B_AUTO  = 6'h02;
    localparam logic [5:0] B_UP    = 6'h04;
    localparam logic [5:0] B_DOWN  = 6'h08;
    localparam logic [5:0] B_PHASE = 6'h10;
    localparam logic [5:0] B_INJ   = 6'h20;

    // fields that a row compares
    localparam int CK_PASS  = 1;
    localparam int CK_FAIL  = 2;
    localparam int CK_FREQ  = 4;
    localparam int CK_MARK  = 8;
    localparam int CK_ELAP  = 16;
    // pass_count at least the row value
    localparam int CK_PMIN  = 32;
    // pass_count unchanged over the whole row
    localparam int CK_HOLD  = 64;
    // mark from the auto running light rule
    localparam int CK_TMARK = 128;
    // elapsed from the mm:ss model
    localparam int CK_CLOCK = 256;

    localparam int PASS_CYCLES  = 2 * `MT_DEPTH + 2;
    localparam int PRESS_CYCLES = 4;
    localparam int PH_CK        = CK_MARK | CK_ELAP | CK_FREQ;

    typedef struct packed {
        logic [5:0]  btn;
        logic [15:0] hold;
        logic [15:0] flags;
        logic [31:0] pass;
        logic [31:0] fail;
        logic [15:0] freq;
        logic [7:0]  mark;
        logic [15:0] elap;
    } row_t;

    logic        clk_pixel;
    logic        rst_n;
    logic [5:0]  btn;
    logic [31:0] pass_count;
    logic [31:0] fail_count;
    logic [15:0] freq;
    logic [15:0] elapsed;
    logic [7:0]  mark;
    logic        busy;

    row_t        rows [$];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          run_cycles = 0;
    logic [31:0] lcg_state;

    memtest_top dut (
        .clk_pixel  (clk_pixel),
        .rst_n      (rst_n),
        .btn        (btn),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .freq       (freq),
        .elapsed    (elapsed),
        .mark       (mark),
        .busy       (busy)
    );

    always #10 clk_pixel = ~clk_pixel;

    // clocks since reset release, same edges that drive the seconds counter
    always @(posedge clk_pixel)
    begin
        if (!rst_n)
            run_cycles <= 0;
        else
            run_cycles <= run_cycles + 1;
    end

    always @(posedge clk_pixel)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout: the stimulus table did not finish within %0d cycles",
                     cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mm:ss word as the display would show it after some clocks
    function automatic logic [15:0] clock_word(input int cycles);
        mt_status_u w;
        w.tm.secs = 8'((cycles / `MT_SEC_TICKS) % 60);
        w.tm.mins = 8'(cycles / (`MT_SEC_TICKS * 60));
        return w;
    endfunction

    function automatic logic [7:0] auto_mark(input int cycles);
        int secs;
        secs = (cycles / `MT_SEC_TICKS) % 60;
        return 8'h80 >> (secs % 16);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want)
        begin
            $display("ERROR at %0t ns: %s got 0x%0h, expected 0x%0h",
                     $time, name, got, want);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // inputs change 2 ns after the rising edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge clk_pixel);
        #2;
    endtask

    task automatic add_row(input logic [5:0] b, input int hold, input int flags,
                           input logic [31:0] p, input logic [31:0] f,
                           input logic [15:0] fr, input logic [7:0] m,
                           input logic [15:0] e);
        row_t r;
        r.btn   = b;
        r.hold  = 16'(hold);
        r.flags = 16'(flags);
        r.pass  = p;
        r.fail  = f;
        r.freq  = fr;
        r.mark  = m;
        r.elap  = e;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] pass_before;
        pass_before = pass_count;
        btn = r.btn;
        repeat (PRESS_CYCLES) next_cycle();
        btn = B_NONE;
        repeat (int'(r.hold)) next_cycle();
        // a running pass has to finish before anything is compared
        while (busy)
            next_cycle();
        repeat (4) next_cycle();

        if ((r.flags & CK_PASS) != 0)
            compare_value("pass_count", pass_count, r.pass);
        if ((r.flags & CK_FAIL) != 0)
            compare_value("fail_count", fail_count, r.fail);
        if ((r.flags & CK_FREQ) != 0)
            compare_value("freq", 32'(freq), 32'(r.freq));
        if ((r.flags & CK_MARK) != 0)
            compare_value("mark", 32'(mark), 32'(r.mark));
        if ((r.flags & CK_ELAP) != 0)
            compare_value("elapsed", 32'(elapsed), 32'(r.elap));
        if ((r.flags & CK_PMIN) != 0)
            compare_value("pass_count >= minimum", 32'(pass_count >= r.pass), 32'd1);
        if ((r.flags & CK_HOLD) != 0)
            compare_value("pass_count", pass_count, pass_before);
        if ((r.flags & CK_TMARK) != 0)
            compare_value("mark", 32'(mark), 32'(auto_mark(run_cycles)));
        if ((r.flags & CK_CLOCK) != 0)
            compare_value("elapsed", 32'(elapsed), 32'(clock_word(run_cycles)));
    endtask

    task automatic build_table();
        // single passes, then an injected fault and recovery
        add_row(B_START, 0, CK_PASS | CK_FAIL | CK_CLOCK, 1, 0, 0, 0, 0);
        add_row(B_INJ, 0, CK_PASS | CK_FAIL, 1, 0, 0, 0, 0);
        add_row(B_START, 0, CK_PASS | CK_FAIL, 1, 1, 0, 0, 0);
        add_row(B_START, 0, CK_PASS | CK_FAIL | CK_MARK, 2, 1, 0, 8'h00, 0);

        // frequency index, saturating at index 0
        add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF160, 0, 0);
        add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF150, 0, 0);
        add_row(B_DOWN, 0, CK_FREQ, 0, 0, 16'hF160, 0, 0);
        add_row(B_DOWN, 0, CK_FREQ, 0, 0, 16'hF167, 0, 0);
        add_row(B_DOWN, 0, CK_FREQ, 0, 0, 16'hF167, 0, 0);

        // walk the whole table up to index 10 and past it
        for (int i = 1; i < 10; i++)
            add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF000 | 16'(MT_FREQ_TABLE[i]), 0, 0);
        add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF070, 0, 0);
        add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF070, 0, 0);
        add_row(B_DOWN, 0, CK_FREQ, 0, 0, 16'hF080, 0, 0);

        // auto-repeat for about three passes, then off and quiet
        add_row(B_AUTO, 3 * PASS_CYCLES + 20, CK_PMIN | CK_FAIL | CK_TMARK,
                2 + 3 - 1, 1, 0, 0, 0);
        add_row(B_AUTO, 0, CK_FAIL | CK_MARK, 0, 1, 0, 8'h00, 0);
        add_row(B_NONE, 100, CK_HOLD | CK_FAIL | CK_MARK | CK_CLOCK, 0, 1, 0, 8'h00, 0);

        // phase mode, up/down move the phase and leave pos alone
        add_row(B_PHASE, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'h0000);
        add_row(B_UP, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'h0001);
        add_row(B_DOWN, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'h0000);
        add_row(B_DOWN, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'hFFFF);
        add_row(B_DOWN, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'hFFFE);
        add_row(B_UP, 0, PH_CK, 0, 0, 16'hF080, 8'hF0, 16'hFFFF);
        add_row(B_PHASE, 0, CK_MARK | CK_CLOCK | CK_FREQ, 0, 0, 16'hF080, 8'h00, 0);
        add_row(B_UP, 0, CK_FREQ, 0, 0, 16'hF070, 0, 0);
    endtask

    initial
    begin
        clk_pixel = 1'b0;
        rst_n     = 1'b0;
        btn       = B_NONE;
        lcg_state = 32'h8c6b1929;
        build_table();
        cycle_limit = rows.size() * (2 * `MT_DEPTH + 40) + 100;

        repeat (8) @(posedge clk_pixel);
        #2;
        rst_n = 1'b1;
        next_cycle();

        // everything idle and cleared, freq shows index 0
        compare_value("pass_count", pass_count, 32'd0);
        compare_value("fail_count", fail_count, 32'd0);
        compare_value("freq", 32'(freq), 32'h0000F167);
        compare_value("elapsed", 32'(elapsed), 32'd0);
        compare_value("mark", 32'(mark), 32'd0);
        compare_value("busy", 32'(busy), 32'd0);

        foreach (rows[i])
        begin
            apply_row(rows[i]);
            // idle gap of 0 to 7 clocks between rows
            lcg_state = lcg_next(lcg_state);
            repeat (int'(lcg_state[31:29])) next_cycle();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/memtest_pkg.sv
rtl/memtest_if.sv
rtl/cmd_decode.sv
rtl/pattern_engine.sv
rtl/result_tally.sv
rtl/memtest_top.sv
bench/memtest_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the memory-test testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module memtest_tb -o memtest_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/memtest_sim > "$LOG" 2>&1 || echo "simulator exited with an error status"

cat "$LOG"

grep -q "TEST FAILED" "$LOG" && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "simulation ended without a result"; exit 1; }

exit 0
